/* compile.f */
dsi_pkg.sv
dsi_axil_decode.sv
dsi_ecc_frame.sv
dphy_lane_serdes.sv
dsi_short_tx.sv
tb_dsi_short_tx.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the DSI short packet testbench with Verilator and runs it
# Exit status is nonzero when the build, the run or a check fails

cd "$(dirname "$0")" || exit 1

TOP=tb_dsi_short_tx
LOG=sim.log

verilator --binary --timing --timescale 1ns/10ps -f compile.f \
   --top-module "$TOP" --Mdir obj_dir -o "$TOP"
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
   echo "Simulation reported a failure, see $LOG"
   exit 1
fi

echo "Simulation passed, see $LOG"
exit 0

/* tb_dsi_short_tx.sv */
// ========================================
// Random header writes, seed 9845
// Lane output checked against an in-bench model
// ========================================

`timescale 1ns/10ps

module tb_dsi_short_tx
   import dsi_pkg::*;
();

   localparam int RAND_WRITES     = 200;
   localparam int NUM_PKTS        = RAND_WRITES + 4;
   localparam int WATCHDOG_CYCLES = NUM_PKTS * 40 * 4 + 1000;

   logic       clk_dsi_i;
   logic       reset_i;
   logic       s_awvalid_i;
   logic       s_awready_o;
   axil_addr_t s_awaddr_i;
   logic       s_wvalid_i;
   logic       s_wready_o;
   axil_data_t s_wdata_i;
   logic       s_bvalid_o;
   logic       s_bready_i;
   axil_resp_t s_bresp_o;
   logic       s_arvalid_i;
   logic       s_arready_o;
   axil_addr_t s_araddr_i;
   logic       s_rvalid_o;
   logic       s_rready_i;
   axil_data_t s_rdata_o;
   axil_resp_t s_rresp_o;
   logic       q_o;
   logic       tq_o;

   int       seed     = 9845;
   int       pass_cnt = 0;
   int       fail_cnt = 0;
   int       okay_cnt = 0;                           // Accepted headers over all tests
   int       pkt_cnt  = 0;
   dsi_hdr_t exp_q[$];                               // Headers still owed to the lane

   dsi_short_tx i_dut (.*);

   initial begin
      clk_dsi_i = 1'b0;
      forever #5 clk_dsi_i = ~clk_dsi_i;
   end

   // Every packet at four times its lane length, plus slack for reset and polling
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk_dsi_i);
      $display("Watchdog expired after %0d cycles, the DUT stopped responding",
               WATCHDOG_CYCLES);
      $display("Test FAILED");
      $finish;
   end

   task automatic log_result(input string name, input logic ok, input string exp,
                             input string act);
      if (ok) begin
         pass_cnt++;
         $display("Pass  %s: %s", name, act);
      end else begin
         fail_cnt++;
         $display("Error %s: expected %s, actual %s", name, exp, act);
      end
   endtask

   task automatic compare_hdr(input string name, input dsi_hdr_t exp, input dsi_hdr_t act);
      log_result(name, act === exp, $sformatf("%h", exp), $sformatf("%h", act));
   endtask

   task automatic compare_ecc(input string name, input dsi_ecc_t exp, input dsi_ecc_t act);
      log_result(name, act === exp, $sformatf("%h", exp), $sformatf("%h", act));
   endtask

   task automatic compare_byte(input string name, input dsi_byte_t exp, input dsi_byte_t act);
      log_result(name, act === exp, $sformatf("%h", exp), $sformatf("%h", act));
   endtask

   task automatic compare_resp(input string name, input axil_resp_t exp,
                               input axil_resp_t act);
      log_result(name, act === exp, $sformatf("%0d", exp), $sformatf("%0d", act));
   endtask

   task automatic compare_data(input string name, input axil_data_t exp,
                               input axil_data_t act);
      log_result(name, act === exp, $sformatf("%h", exp), $sformatf("%h", act));
   endtask

   // DSI header ECC, one parity equation per bit, d[0] is DI bit 0
   function automatic dsi_ecc_t model_ecc(input dsi_hdr_t hdr);
      logic [23:0] d;
      dsi_ecc_t    e;
      d    = hdr;
      e    = '0;
      e[0] = ^{d[0], d[1], d[2], d[4], d[5], d[7], d[10], d[11], d[13],
               d[16], d[20], d[21], d[22], d[23]};
      e[1] = ^{d[0], d[1], d[3], d[4], d[6], d[8], d[10], d[12], d[14],
               d[17], d[20], d[21], d[22], d[23]};
      e[2] = ^{d[0], d[2], d[3], d[5], d[6], d[9], d[11], d[12], d[15],
               d[18], d[20], d[21], d[22]};
      e[3] = ^{d[1], d[2], d[3], d[7], d[8], d[9], d[13], d[14], d[15],
               d[19], d[20], d[21], d[23]};
      e[4] = ^{d[4], d[5], d[6], d[7], d[8], d[9], d[16], d[17], d[18],
               d[19], d[20], d[22], d[23]};
      e[5] = ^{d[10], d[11], d[12], d[13], d[14], d[15], d[16], d[17], d[18],
               d[19], d[21], d[22], d[23]};
      return e;                                      // Bits 7:6 stay zero
   endfunction

   task automatic write_reg(input axil_addr_t addr, input axil_data_t data,
                            output axil_resp_t resp);
      @(posedge clk_dsi_i);
      s_awvalid_i <= 1'b1;
      s_awaddr_i  <= addr;
      s_wvalid_i  <= 1'b1;
      s_wdata_i   <= data;
      do begin
         @(negedge clk_dsi_i);
      end while (!s_awready_o && !s_wready_o);
      if (s_awready_o !== s_wready_o) begin
         fail_cnt++;
         $display("AWREADY and WREADY did not pulse together on a write to %h", addr);
      end
      @(posedge clk_dsi_i);                          // Handshake on this edge
      s_awvalid_i <= 1'b0;
      s_wvalid_i  <= 1'b0;
      do begin
         @(negedge clk_dsi_i);
      end while (!s_bvalid_o);
      resp = s_bresp_o;
   endtask

   task automatic read_reg(input axil_addr_t addr, output axil_data_t data,
                           output axil_resp_t resp);
      @(posedge clk_dsi_i);
      s_arvalid_i <= 1'b1;
      s_araddr_i  <= addr;
      do begin
         @(negedge clk_dsi_i);
      end while (!s_arready_o);
      @(posedge clk_dsi_i);
      s_arvalid_i <= 1'b0;
      do begin
         @(negedge clk_dsi_i);
      end while (!s_rvalid_o);
      data = s_rdata_o;
      resp = s_rresp_o;
   endtask

   // Only headers answered OKAY are expected on the lane
   task automatic send_header(input axil_data_t data, output axil_resp_t resp);
      dsi_hdr_t hdr;
      hdr = data[23:0];
      write_reg(ADDR_HDR, data, resp);
      if (resp == RESP_OKAY) begin
         exp_q.push_back(hdr);
         okay_cnt++;
      end
   endtask

   task automatic wait_lane_idle();
      do begin
         @(negedge clk_dsi_i);
      end while (exp_q.size() != 0 || !tq_o);
   endtask

   task automatic check_packet(input logic [39:0] bits);
      dsi_hdr_t hdr;
      string    tag;
      tag = $sformatf("packet %0d", pkt_cnt);
      pkt_cnt++;
      if (exp_q.size() == 0) begin
         fail_cnt++;
         $display("%s appeared on the lane without an accepted write", tag);
      end else begin
         hdr = exp_q.pop_front();
         compare_byte({tag, " sync"}, DSI_SYNC, bits[7:0]);
         compare_hdr({tag, " header"}, hdr, bits[31:8]);
         compare_ecc({tag, " ecc"}, model_ecc(hdr), bits[39:32]);
      end
   endtask

   // Lane monitor, first bit out ends up in bits[0] after 40 shifts
   initial begin
      logic [39:0] bits;
      int          nbits;
      nbits = 0;
      forever begin
         @(negedge clk_dsi_i);
         if (reset_i) begin
            nbits = 0;
         end else if (!tq_o) begin
            bits = {q_o, bits[39:1]};
            nbits++;
            if (nbits == 40) begin
               check_packet(bits);
               nbits = 0;
            end
         end else if (nbits != 0) begin
            fail_cnt++;
            $display("Lane released after %0d bits, in the middle of a packet", nbits);
            nbits = 0;
         end
      end
   end

   initial begin
      axil_resp_t resp;
      axil_data_t rdata;
      axil_data_t status;
      int         accepted;
      reset_i     <= 1'b1;
      s_awvalid_i <= 1'b0;
      s_awaddr_i  <= '0;
      s_wvalid_i  <= 1'b0;
      s_wdata_i   <= '0;
      s_bready_i  <= 1'b1;
      s_arvalid_i <= 1'b0;
      s_araddr_i  <= '0;
      s_rready_i  <= 1'b1;
      repeat (3) @(posedge clk_dsi_i);
      reset_i <= 1'b0;
      @(negedge clk_dsi_i);

      log_result("reset lane released", tq_o === 1'b1, "1", $sformatf("%b", tq_o));
      read_reg(ADDR_STATUS, rdata, resp);
      compare_resp("reset status resp", RESP_OKAY, resp);
      compare_data("reset status", '0, rdata);

      send_header($random(seed), resp);
      compare_resp("single write resp", RESP_OKAY, resp);
      wait_lane_idle();

      // Gaps of 0 to 63 cycles mix accepted and refused writes
      accepted = okay_cnt;
      for (int i = 0; i < RAND_WRITES; i++) begin
         repeat ($unsigned($random(seed)) % 64) @(posedge clk_dsi_i);
         send_header($random(seed), resp);
      end
      wait_lane_idle();
      $display("Random stream done, %0d of %0d writes accepted",
               okay_cnt - accepted, RAND_WRITES);

      // Pending bit from a status poll predicts each response
      for (int i = 0; i < 3; i++) begin
         read_reg(ADDR_STATUS, status, resp);
         send_header($random(seed), resp);
         compare_resp($sformatf("back-pressure write %0d resp", i),
                      status[0] ? RESP_SLVERR : RESP_OKAY, resp);
      end

      write_reg(ADDR_STATUS, 32'h1, resp);
      compare_resp("status write resp", RESP_SLVERR, resp);
      write_reg(4'h8, 32'h0012_3456, resp);
      compare_resp("unused write resp", RESP_SLVERR, resp);
      read_reg(4'hC, rdata, resp);
      compare_resp("unused read resp", RESP_SLVERR, resp);
      compare_data("unused read data", '0, rdata);
      read_reg(ADDR_HDR, rdata, resp);
      compare_resp("header read resp", RESP_OKAY, resp);
      compare_data("header read data", '0, rdata);

      wait_lane_idle();
      status       = '0;
      status[15:8] = okay_cnt[7:0];                  // Count wraps at 256, pending clear
      read_reg(ADDR_STATUS, rdata, resp);
      compare_resp("final status resp", RESP_OKAY, resp);
      compare_data("final status", status, rdata);

      $display("Checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

/* dsi_short_tx.sv */
// ========================================
// Single lane DSI short packet transmitter
// HS only, no LP or escape signalling
// ========================================

`timescale 1ns/10ps

module dsi_short_tx
   import dsi_pkg::*;
(
   input  logic       clk_dsi_i,
   input  logic       reset_i,
   input  logic       s_awvalid_i,
   output logic       s_awready_o,
   input  axil_addr_t s_awaddr_i,
   input  logic       s_wvalid_i,
   output logic       s_wready_o,
   input  axil_data_t s_wdata_i,
   output logic       s_bvalid_o,
   input  logic       s_bready_i,
   output axil_resp_t s_bresp_o,
   input  logic       s_arvalid_i,
   output logic       s_arready_o,
   input  axil_addr_t s_araddr_i,
   output logic       s_rvalid_o,
   input  logic       s_rready_i,
   output axil_data_t s_rdata_o,
   output axil_resp_t s_rresp_o,
   output logic       q_o,
   output logic       tq_o
);

   dsi_cmd_t       cmd;
   logic           cmd_ready;
   dsi_lane_byte_t lane_byte;
   logic           byte_ready;

   dsi_axil_decode i_decode (
      .clk_dsi_i   (clk_dsi_i),
      .reset_i     (reset_i),
      .s_awvalid_i (s_awvalid_i),
      .s_awready_o (s_awready_o),
      .s_awaddr_i  (s_awaddr_i),
      .s_wvalid_i  (s_wvalid_i),
      .s_wready_o  (s_wready_o),
      .s_wdata_i   (s_wdata_i),
      .s_bvalid_o  (s_bvalid_o),
      .s_bready_i  (s_bready_i),
      .s_bresp_o   (s_bresp_o),
      .s_arvalid_i (s_arvalid_i),
      .s_arready_o (s_arready_o),
      .s_araddr_i  (s_araddr_i),
      .s_rvalid_o  (s_rvalid_o),
      .s_rready_i  (s_rready_i),
      .s_rdata_o   (s_rdata_o),
      .s_rresp_o   (s_rresp_o),
      .cmd_o       (cmd),
      .cmd_ready_i (cmd_ready)
   );

   dsi_ecc_frame i_frame (
      .clk_dsi_i    (clk_dsi_i),
      .reset_i      (reset_i),
      .cmd_i        (cmd),
      .cmd_ready_o  (cmd_ready),
      .lane_byte_o  (lane_byte),
      .byte_ready_i (byte_ready)
   );

   dphy_lane_serdes i_serdes (
      .clk_dsi_i    (clk_dsi_i),
      .reset_i      (reset_i),
      .lane_byte_i  (lane_byte),
      .byte_ready_o (byte_ready),
      .q_o          (q_o),
      .tq_o         (tq_o)
   );

endmodule

/* dphy_lane_serdes.sv */
// ========================================
// Behavioral 8:1 lane serializer, LSB first
// One bit per clk_dsi_i, no serdes clock
// ========================================

`timescale 1ns/10ps

module dphy_lane_serdes
   import dsi_pkg::*;
(
   input  logic           clk_dsi_i,
   input  logic           reset_i,
   input  dsi_lane_byte_t lane_byte_i,
   output logic           byte_ready_o,
   output logic           q_o,
   output logic           tq_o
);

   logic       active_q;
   logic [2:0] bit_cnt_q;
   dsi_byte_t  shift_q;
   logic       load;

   // Ready when idle or on the last bit, so bytes chain without a gap
   assign byte_ready_o = !active_q || (bit_cnt_q == 3'd7);
   assign load         = lane_byte_i.valid && byte_ready_o;

   always_ff @(posedge clk_dsi_i) begin
      if (reset_i) begin
         active_q  <= 1'b0;
         bit_cnt_q <= '0;
      end else if (load) begin
         active_q  <= 1'b1;
         bit_cnt_q <= '0;
      end else if (active_q) begin
         bit_cnt_q <= bit_cnt_q + 3'd1;
         if (bit_cnt_q == 3'd7)
            active_q <= 1'b0;                        // Nothing queued, release lane
      end
   end

   always_ff @(posedge clk_dsi_i) begin
      if (load)
         shift_q <= lane_byte_i.data;
      else if (active_q)
         shift_q <= {1'b0, shift_q[7:1]};
   end

   // Low drive while released
   assign q_o  = active_q & shift_q[0];
   assign tq_o = !active_q;                          // High means tristated

endmodule

/* dsi_ecc_frame.sv */
// ========================================
// Short packet framer, five bytes per packet
// Takes a new header only when idle
// ========================================

`timescale 1ns/10ps

module dsi_ecc_frame
   import dsi_pkg::*;
(
   input  logic           clk_dsi_i,
   input  logic           reset_i,
   input  dsi_cmd_t       cmd_i,
   output logic           cmd_ready_o,
   output dsi_lane_byte_t lane_byte_o,
   input  logic           byte_ready_i
);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_SYNC,
      ST_DI,
      ST_D0,
      ST_D1,
      ST_ECC
   } frame_state_t;

   frame_state_t   state_q;
   dsi_hdr_t       hdr_q;
   dsi_ecc_t       ecc_q;
   dsi_ecc_t       ecc_calc;
   dsi_lane_byte_t out_byte;
   logic           take;

   assign cmd_ready_o = (state_q == ST_IDLE);
   assign take        = cmd_i.valid && cmd_ready_o;

   // Each parity bit covers the header bits its mask selects
   assign ecc_calc = {2'b00,
                      ^(cmd_i.hdr & ECC_MASK5),
                      ^(cmd_i.hdr & ECC_MASK4),
                      ^(cmd_i.hdr & ECC_MASK3),
                      ^(cmd_i.hdr & ECC_MASK2),
                      ^(cmd_i.hdr & ECC_MASK1),
                      ^(cmd_i.hdr & ECC_MASK0)};

   always_ff @(posedge clk_dsi_i) begin
      if (reset_i) begin
         state_q <= ST_IDLE;
      end else begin
         case (state_q)
            ST_IDLE: if (take) state_q <= ST_SYNC;
            ST_SYNC: if (byte_ready_i) state_q <= ST_DI;
            ST_DI:   if (byte_ready_i) state_q <= ST_D0;
            ST_D0:   if (byte_ready_i) state_q <= ST_D1;
            ST_D1:   if (byte_ready_i) state_q <= ST_ECC;
            ST_ECC:  if (byte_ready_i) state_q <= ST_IDLE;
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   // Header and ECC held for the whole packet
   always_ff @(posedge clk_dsi_i) begin
      if (take) begin
         hdr_q <= cmd_i.hdr;
         ecc_q <= ecc_calc;
      end
   end

   always_comb begin
      out_byte.valid = (state_q != ST_IDLE);
      case (state_q)
         ST_SYNC: out_byte.data = DSI_SYNC;
         ST_DI:   out_byte.data = hdr_q.di;
         ST_D0:   out_byte.data = hdr_q.d0;
         ST_D1:   out_byte.data = hdr_q.d1;
         ST_ECC:  out_byte.data = ecc_q;
         default: out_byte.data = '0;
      endcase
   end

   assign lane_byte_o = out_byte;

endmodule

/* dsi_axil_decode.sv */
// ========================================
// AXI4-Lite slave, one transaction per channel
// Holds a single pending header, no queue
// ========================================

`timescale 1ns/10ps

module dsi_axil_decode
   import dsi_pkg::*;
(
   input  logic       clk_dsi_i,
   input  logic       reset_i,
   input  logic       s_awvalid_i,
   output logic       s_awready_o,
   input  axil_addr_t s_awaddr_i,
   input  logic       s_wvalid_i,
   output logic       s_wready_o,
   input  axil_data_t s_wdata_i,
   output logic       s_bvalid_o,
   input  logic       s_bready_i,
   output axil_resp_t s_bresp_o,
   input  logic       s_arvalid_i,
   output logic       s_arready_o,
   input  axil_addr_t s_araddr_i,
   output logic       s_rvalid_o,
   input  logic       s_rready_i,
   output axil_data_t s_rdata_o,
   output axil_resp_t s_rresp_o,
   output dsi_cmd_t   cmd_o,
   input  logic       cmd_ready_i
);

   logic       wr_take;
   logic       rd_take;
   logic       hdr_ok;
   logic       pending_q;
   dsi_hdr_t   hdr_q;
   dsi_byte_t  count_q;
   logic       bvalid_q;
   axil_resp_t bresp_q;
   logic       rvalid_q;
   axil_data_t rdata_q;
   axil_resp_t rresp_q;
   axil_data_t rd_data;
   axil_resp_t rd_resp;

   // Accept only with no response outstanding
   assign wr_take = s_awvalid_i && s_wvalid_i && !bvalid_q;
   assign rd_take = s_arvalid_i && !rvalid_q;
   assign hdr_ok  = (s_awaddr_i == ADDR_HDR) && !pending_q;  // Refused while one is held

   assign s_awready_o = wr_take;
   assign s_wready_o  = wr_take;
   assign s_arready_o = rd_take;

   always_ff @(posedge clk_dsi_i) begin
      if (reset_i) begin
         bvalid_q <= 1'b0;
         rvalid_q <= 1'b0;
      end else begin
         if (wr_take)
            bvalid_q <= 1'b1;
         else if (s_bready_i)
            bvalid_q <= 1'b0;
         if (rd_take)
            rvalid_q <= 1'b1;
         else if (s_rready_i)
            rvalid_q <= 1'b0;
      end
   end

   // Response payload
   always_ff @(posedge clk_dsi_i) begin
      if (wr_take)
         bresp_q <= hdr_ok ? RESP_OKAY : RESP_SLVERR;
      if (rd_take) begin
         rdata_q <= rd_data;
         rresp_q <= rd_resp;
      end
   end

   // Pending command and accepted count
   always_ff @(posedge clk_dsi_i) begin
      if (reset_i) begin
         pending_q <= 1'b0;
         count_q   <= '0;
      end else if (wr_take && hdr_ok) begin
         pending_q <= 1'b1;
         count_q   <= count_q + 8'd1;                // Wraps at 256
      end else if (cmd_ready_i) begin
         pending_q <= 1'b0;                          // Framer took it
      end
   end

   always_ff @(posedge clk_dsi_i) begin
      if (wr_take && hdr_ok)
         hdr_q <= s_wdata_i[23:0];
   end

   // Read mux
   always_comb begin
      rd_data = '0;
      rd_resp = RESP_OKAY;
      case (s_araddr_i)
         ADDR_HDR:    rd_data = '0;
         ADDR_STATUS: begin
            rd_data[0]    = pending_q;
            rd_data[15:8] = count_q;
         end
         default:     rd_resp = RESP_SLVERR;
      endcase
   end

   assign s_bvalid_o = bvalid_q;
   assign s_bresp_o  = bresp_q;
   assign s_rvalid_o = rvalid_q;
   assign s_rdata_o  = rdata_q;
   assign s_rresp_o  = rresp_q;

   assign cmd_o = '{valid: pending_q, hdr: hdr_q};

endmodule

/* dsi_pkg.sv */
// ========================================
// Shared types for the DSI short packet TX
// Header bit 0 is DI bit 0, sent first
// ========================================

package dsi_pkg;

   // Lane and bus widths
   typedef logic [7:0]  dsi_byte_t;
   typedef logic [7:0]  dsi_ecc_t;     // Bits 7:6 always zero
   typedef logic [3:0]  axil_addr_t;
   typedef logic [31:0] axil_data_t;
   typedef logic [1:0]  axil_resp_t;

   localparam axil_resp_t RESP_OKAY   = 2'd0;
   localparam axil_resp_t RESP_SLVERR = 2'd2;

   // Register map
   localparam axil_addr_t ADDR_HDR    = 4'h0;  // Write only, read as zero
   localparam axil_addr_t ADDR_STATUS = 4'h4;  // Pending and packet count

   // High-speed leader byte ahead of every packet
   localparam dsi_byte_t DSI_SYNC = 8'hB8;

   // Hamming table, one mask per ECC bit over the 24 header bits
   localparam logic [23:0] ECC_MASK0 = 24'hF12CB7;
   localparam logic [23:0] ECC_MASK1 = 24'hF2555B;
   localparam logic [23:0] ECC_MASK2 = 24'h749A6D;
   localparam logic [23:0] ECC_MASK3 = 24'hB8E38E;
   localparam logic [23:0] ECC_MASK4 = 24'hDF03F0;
   localparam logic [23:0] ECC_MASK5 = 24'hEFFC00;

   // Packet header, di lands in bits 7:0
   typedef struct packed {
      dsi_byte_t d1;
      dsi_byte_t d0;
      dsi_byte_t di;
   } dsi_hdr_t;

   // Decode to framer
   typedef struct packed {
      logic     valid;
      dsi_hdr_t hdr;
   } dsi_cmd_t;

   // Framer to serializer
   typedef struct packed {
      logic      valid;
      dsi_byte_t data;
   } dsi_lane_byte_t;

endpackage
